// ==== tb.f ====
roc_pkg.sv
roc_region_select.sv
roc_flush_counter.sv
roc_line_store.sv
roc_ctrl.sv
roc_top.sv
roc_chk.sv
tb_roc.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the read-only cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_roc -f tb.f -o Vtb_roc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_roc)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q -F -x "=== PASS ==="; then
  exit 0
fi
exit 1

// ==== tb_roc.sv ====
// --------------------------------------------------
// Read-only cache testbench
// Directed reads against a latency-randomized memory
// model, covering hits, bypass, eviction, error lines
// and flush
// --------------------------------------------------

`default_nettype none

module tb_roc;
  timeunit 1ns;
  timeprecision 100ps;

  import roc_pkg::*;

  localparam int unsigned line_count     = 8;
  localparam int unsigned timeout_cycles = 50;

  logic  clk, reset, enable, req, req_lock, flush;
  addr_t start_addr, end_addr, req_addr, mem_addr, last_addr;
  logic  ready, rsp_valid, rsp_error, mem_req, mem_rvalid, mem_err;
  word_t rsp_data, mem_rdata;

  int unsigned error_count;
  int unsigned timeout_count;
  int unsigned mem_req_count;

  roc_top #(
    .line_count ( line_count )
  ) dut0 (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .enable_i     ( enable     ),
    .start_addr_i ( start_addr ),
    .end_addr_i   ( end_addr   ),
    .req_i        ( req        ),
    .req_addr_i   ( req_addr   ),
    .req_lock_i   ( req_lock   ),
    .ready_o      ( ready      ),
    .rsp_valid_o  ( rsp_valid  ),
    .rsp_data_o   ( rsp_data   ),
    .rsp_error_o  ( rsp_error  ),
    .flush_i      ( flush      ),
    .mem_req_o    ( mem_req    ),
    .mem_addr_o   ( mem_addr   ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  ),
    .mem_err_i    ( mem_err    )
  );

  always #2 clk = ~clk;

  // Memory contents follow the word address
  function automatic word_t model_word(input addr_t addr);
    return (addr & ~32'h3) ^ 32'h5a5a_0000;
  endfunction

  // Page 0x3000 answers with an error
  function automatic logic in_error_page(input addr_t addr);
    return addr[31:12] == 20'h00003;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  // --------------------------------------------------
  // Memory model, one outstanding request
  // --------------------------------------------------
  always begin
    addr_t       addr;
    int unsigned delay;
    @(negedge clk);
    if (mem_req) begin
      mem_req_count++;
      addr  = mem_addr;
      delay = 1 + ($urandom % 5);
      if (addr !== (last_addr & ~32'h3)) begin
        report_mismatch($sformatf("mem_addr_o %h for request %h", addr, last_addr));
      end
      repeat (delay) @(posedge clk);
      #1;
      mem_rvalid = 1'b1;
      mem_rdata  = model_word(addr);
      mem_err    = in_error_page(addr);
      @(posedge clk);
      #1;
      mem_rvalid = 1'b0;
    end
  end

  task automatic wait_ready();
    int unsigned cycles;
    cycles = 0;
    @(negedge clk);
    while (!ready && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!ready) begin
      $display("Timeout at %0t ns: ready_o stayed low", $time);
      timeout_count++;
    end
  endtask

  // One read, checked for data, error and memory traffic
  task automatic read_check(input addr_t addr, input logic lock, input int unsigned exp_reqs,
                            input string name);
    int unsigned reqs_before;
    int unsigned cycles;
    wait_ready();
    reqs_before = mem_req_count;
    last_addr   = addr;
    @(posedge clk);
    #1;
    req      = 1'b1;
    req_addr = addr;
    req_lock = lock;
    @(posedge clk);
    #1;
    req      = 1'b0;
    req_lock = 1'b0;
    cycles   = 0;
    @(negedge clk);
    while (!rsp_valid && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!rsp_valid) begin
      $display("Timeout at %0t ns: no response to %s at %h", $time, name, addr);
      timeout_count++;
    end else begin
      if (rsp_data !== model_word(addr)) begin
        report_mismatch($sformatf("%s %h data %h", name, addr, rsp_data));
      end
      if (rsp_error !== in_error_page(addr)) begin
        report_mismatch($sformatf("%s %h error %b", name, addr, rsp_error));
      end
      if (mem_req_count - reqs_before != exp_reqs) begin
        report_mismatch($sformatf("%s %h made %0d memory requests, expected %0d", name, addr,
                                  mem_req_count - reqs_before, exp_reqs));
      end
      @(negedge clk);
      if (rsp_valid) begin
        report_mismatch($sformatf("%s %h rsp_valid_o longer than one cycle", name, addr));
      end
    end
  endtask

  task automatic flush_check();
    int unsigned low_cycles;
    int unsigned reqs_before;
    wait_ready();
    reqs_before = mem_req_count;
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush      = 1'b0;
    // Out-of-region read offered while the sweep runs
    req        = 1'b1;
    req_addr   = 32'h0000_4000;
    low_cycles = ready ? 0 : 1;
    @(posedge clk);
    #1;
    req = 1'b0;
    @(negedge clk);
    while (!ready && low_cycles < timeout_cycles) begin
      low_cycles++;
      @(negedge clk);
    end
    if (!ready) begin
      $display("Timeout at %0t ns: flush never finished", $time);
      timeout_count++;
    end else if (low_cycles != line_count) begin
      report_mismatch($sformatf("flush held ready_o low %0d cycles", low_cycles));
    end
    if (mem_req_count != reqs_before) begin
      report_mismatch("read offered during flush reached memory");
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_reset_and_hit();
    @(negedge clk);
    if (!ready || rsp_valid || mem_req) begin
      report_mismatch("outputs after reset");
    end
    // Unaligned byte address, line holds the aligned word
    read_check(32'h0000_1006, 1'b0, 1, "first read");
    read_check(32'h0000_1006, 1'b0, 0, "repeated read");
  endtask

  task automatic test_bypass_paths();
    repeat (2) read_check(32'h0000_4000, 1'b0, 1, "out-of-region read");
    repeat (2) read_check(32'h0000_1008, 1'b1, 1, "locked read");
    @(posedge clk);
    #1;
    enable = 1'b0;
    repeat (2) read_check(32'h0000_100c, 1'b0, 1, "disabled read");
    @(posedge clk);
    #1;
    enable = 1'b1;
    // Bypass left the line empty
    read_check(32'h0000_100c, 1'b0, 1, "read after re-enable");
  endtask

  task automatic test_eviction();
    read_check(32'h0000_1010, 1'b0, 1, "first of index pair");
    read_check(32'h0000_1030, 1'b0, 1, "second of index pair");
    read_check(32'h0000_1010, 1'b0, 1, "evicted read");
  endtask

  task automatic test_error_line();
    read_check(32'h0000_3008, 1'b0, 1, "error refill");
    read_check(32'h0000_3008, 1'b0, 0, "error hit");
  endtask

  // First and last line index both cleared by the sweep
  task automatic test_flush();
    read_check(32'h0000_1040, 1'b0, 1, "read before flush");
    read_check(32'h0000_1040, 1'b0, 0, "hit before flush");
    read_check(32'h0000_101c, 1'b0, 1, "last index before flush");
    flush_check();
    read_check(32'h0000_1040, 1'b0, 1, "read after flush");
    read_check(32'h0000_101c, 1'b0, 1, "last index after flush");
  endtask

  initial begin
    void'($urandom(32'he9aa));
    clk           = 1'b0;
    reset         = 1'b1;
    enable        = 1'b1;
    start_addr    = 32'h0000_1000;
    end_addr      = 32'h0000_4000;
    req           = 1'b0;
    req_addr      = '0;
    req_lock      = 1'b0;
    flush         = 1'b0;
    mem_rvalid    = 1'b0;
    mem_rdata     = '0;
    mem_err       = 1'b0;
    last_addr     = '0;
    error_count   = 0;
    timeout_count = 0;
    mem_req_count = 0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    test_reset_and_hit();
    test_bypass_paths();
    test_eviction();
    test_error_line();
    test_flush();

    $display("Mismatches: %0d, timeouts: %0d, memory requests: %0d",
             error_count, timeout_count, mem_req_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : tb_roc

`default_nettype wire

// ==== roc_chk.sv ====
// --------------------------------------------------
// Controller checker
// Assertions on memory and response strobes and on
// the flush sweep, bound into the controller
// --------------------------------------------------

`default_nettype none

module roc_chk (
  input logic                 clk_i,
  input logic                 reset_i,
  input roc_pkg::ctrl_state_e state_i,
  input logic                 req_i,
  input logic                 ready_i,
  input logic                 mem_req_i,
  input logic                 rsp_valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  import roc_pkg::*;

  // Memory strobe is a single-cycle pulse
  mem_req_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_i |=> !mem_req_i)
    else $error("mem_req_o high two cycles in a row");

  // Response pulse sits in the busy window and ends it
  rsp_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i |-> !ready_i ##1 ready_i)
    else $error("ready_o wrong around rsp_valid_o");

  // Sweep ignores requests
  flush_no_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    ((state_i == st_flush) && req_i) |=> !mem_req_i)
    else $error("request taken during flush");

endmodule : roc_chk

bind roc_ctrl roc_chk chk0 (
  .clk_i       ( clk_i       ),
  .reset_i     ( reset_i     ),
  .state_i     ( state_q     ),
  .req_i       ( req_i       ),
  .ready_i     ( ready_o     ),
  .mem_req_i   ( mem_req_o   ),
  .rsp_valid_i ( rsp_valid_o )
);

`default_nettype wire

// ==== roc_top.sv ====
// --------------------------------------------------
// Read-only line cache, top level
// Direct-mapped cache between a requester and a word
// memory, with a runtime cacheable region and flush
// --------------------------------------------------

`default_nettype none

module roc_top #(
  parameter int unsigned line_count = 16
) (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           enable_i,
  input  roc_pkg::addr_t start_addr_i,
  input  roc_pkg::addr_t end_addr_i,
  input  logic           req_i,
  input  roc_pkg::addr_t req_addr_i,
  input  logic           req_lock_i,
  output logic           ready_o,
  output logic           rsp_valid_o,
  output roc_pkg::word_t rsp_data_o,
  output logic           rsp_error_o,
  input  logic           flush_i,
  output logic           mem_req_o,
  output roc_pkg::addr_t mem_addr_o,
  input  logic           mem_rvalid_i,
  input  roc_pkg::word_t mem_rdata_i,
  input  logic           mem_err_i
);

  import roc_pkg::*;

  localparam int unsigned index_bits = $clog2(line_count);

  logic                  cacheable;
  addr_t                 lookup_addr;
  logic                  hit;
  word_t                 line_data;
  logic                  line_error;
  logic                  fill;
  logic                  flush_start;
  logic                  flush_step;
  logic                  flush_last;
  logic                  clear;
  logic [index_bits-1:0] clear_index;

  roc_region_select i_region_select (
    .enable_i     ( enable_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_lock_i   ( req_lock_i   ),
    .start_addr_i ( start_addr_i ),
    .end_addr_i   ( end_addr_i   ),
    .cacheable_o  ( cacheable    )
  );

  roc_flush_counter #(
    .line_count ( line_count )
  ) i_flush_counter (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .start_i ( flush_start ),
    .step_i  ( flush_step  ),
    .index_o ( clear_index ),
    .last_o  ( flush_last  )
  );

  // Refill writes the line at the address being looked up
  roc_line_store #(
    .line_count ( line_count )
  ) i_line_store (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .lookup_addr_i ( lookup_addr ),
    .hit_o         ( hit         ),
    .data_o        ( line_data   ),
    .error_o       ( line_error  ),
    .fill_i        ( fill        ),
    .fill_addr_i   ( lookup_addr ),
    .fill_data_i   ( mem_rdata_i ),
    .fill_error_i  ( mem_err_i   ),
    .clear_i       ( clear       ),
    .clear_index_i ( clear_index )
  );

  roc_ctrl i_ctrl (
    .clk_i         ( clk_i        ),
    .reset_i       ( reset_i      ),
    .req_i         ( req_i        ),
    .req_addr_i    ( req_addr_i   ),
    .cacheable_i   ( cacheable    ),
    .flush_i       ( flush_i      ),
    .ready_o       ( ready_o      ),
    .lookup_addr_o ( lookup_addr  ),
    .hit_i         ( hit          ),
    .line_data_i   ( line_data    ),
    .line_error_i  ( line_error   ),
    .fill_o        ( fill         ),
    .flush_start_o ( flush_start  ),
    .flush_step_o  ( flush_step   ),
    .flush_last_i  ( flush_last   ),
    .clear_o       ( clear        ),
    .mem_req_o     ( mem_req_o    ),
    .mem_addr_o    ( mem_addr_o   ),
    .mem_rvalid_i  ( mem_rvalid_i ),
    .mem_rdata_i   ( mem_rdata_i  ),
    .mem_err_i     ( mem_err_i    ),
    .rsp_valid_o   ( rsp_valid_o  ),
    .rsp_data_o    ( rsp_data_o   ),
    .rsp_error_o   ( rsp_error_o  )
  );

endmodule : roc_top

`default_nettype wire

// ==== roc_ctrl.sv ====
// --------------------------------------------------
// Cache controller
// Accepts one read at a time, then sequences lookup,
// refill or bypass and the response pulse, and runs
// the flush sweep over all lines
// --------------------------------------------------

`default_nettype none

module roc_ctrl (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           req_i,
  input  roc_pkg::addr_t req_addr_i,
  input  logic           cacheable_i,
  input  logic           flush_i,
  output logic           ready_o,
  output roc_pkg::addr_t lookup_addr_o,
  input  logic           hit_i,
  input  roc_pkg::word_t line_data_i,
  input  logic           line_error_i,
  output logic           fill_o,
  output logic           flush_start_o,
  output logic           flush_step_o,
  input  logic           flush_last_i,
  output logic           clear_o,
  output logic           mem_req_o,
  output roc_pkg::addr_t mem_addr_o,
  input  logic           mem_rvalid_i,
  input  roc_pkg::word_t mem_rdata_i,
  input  logic           mem_err_i,
  output logic           rsp_valid_o,
  output roc_pkg::word_t rsp_data_o,
  output logic           rsp_error_o
);

  import roc_pkg::*;

  ctrl_state_e state_q, state_d;

  addr_t addr_q;
  word_t rsp_data_q;
  logic  rsp_error_q;
  logic  mem_req_q;

  logic accept;
  logic mem_return;
  logic lookup_hit;

  // Flush wins over a read in the same cycle
  assign accept     = (state_q == st_idle) && req_i && !flush_i;
  assign mem_return = ((state_q == st_refill) || (state_q == st_bypass)) && mem_rvalid_i;
  assign lookup_hit = (state_q == st_lookup) && hit_i;

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (flush_i) begin
          state_d = st_flush;
        end else if (req_i) begin
          state_d = cacheable_i ? st_lookup : st_bypass;
        end
      end
      st_lookup:  state_d = hit_i ? st_respond : st_refill;
      st_refill,
      st_bypass: begin
        if (mem_rvalid_i) begin
          state_d = st_respond;
        end
      end
      st_respond: state_d = st_idle;
      st_flush: begin
        if (flush_last_i) begin
          state_d = st_idle;
        end
      end
      default:    state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= st_idle;
      mem_req_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // One memory strobe on entry to refill or bypass
      mem_req_q <= (accept && !cacheable_i) || ((state_q == st_lookup) && !hit_i);
    end
  end

  // --------------------------------------------------
  // Request address and response payload
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= {req_addr_i[addr_width-1:byte_offset_bits], {byte_offset_bits{1'b0}}};
    end
    if (lookup_hit) begin
      rsp_data_q  <= line_data_i;
      rsp_error_q <= line_error_i;
    end else if (mem_return) begin
      rsp_data_q  <= mem_rdata_i;
      rsp_error_q <= mem_err_i;
    end
  end

  assign ready_o       = (state_q == st_idle);
  assign lookup_addr_o = addr_q;
  assign mem_addr_o    = addr_q;
  assign mem_req_o     = mem_req_q;

  // Line written as the refill data comes back
  assign fill_o = (state_q == st_refill) && mem_rvalid_i;

  // Flush sweep strobes
  assign flush_start_o = (state_q == st_idle) && flush_i;
  assign flush_step_o  = (state_q == st_flush);
  assign clear_o       = (state_q == st_flush);

  assign rsp_valid_o = (state_q == st_respond);
  assign rsp_data_o  = rsp_data_q;
  assign rsp_error_o = rsp_error_q;

endmodule : roc_ctrl

`default_nettype wire

// ==== roc_line_store.sv ====
// --------------------------------------------------
// Line store
// Direct-mapped valid, error, tag and data arrays,
// one word per line, with a combinational lookup,
// a fill port and a per-index clear port
// --------------------------------------------------

`default_nettype none

module roc_line_store #(
  parameter int unsigned line_count = 16
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  roc_pkg::addr_t                lookup_addr_i,
  output logic                          hit_o,
  output roc_pkg::word_t                data_o,
  output logic                          error_o,
  input  logic                          fill_i,
  input  roc_pkg::addr_t                fill_addr_i,
  input  roc_pkg::word_t                fill_data_i,
  input  logic                          fill_error_i,
  input  logic                          clear_i,
  input  logic [$clog2(line_count)-1:0] clear_index_i
);

  import roc_pkg::*;

  localparam int unsigned index_bits = $clog2(line_count);
  localparam int unsigned tag_bits   = addr_width - byte_offset_bits - index_bits;

  typedef logic [index_bits-1:0] index_t;
  typedef logic [tag_bits-1:0]   tag_t;

  logic [line_count-1:0] valid_q;
  logic [line_count-1:0] error_q;
  tag_t                  tag_q  [line_count];
  word_t                 data_q [line_count];

  index_t lookup_index;
  tag_t   lookup_tag;
  index_t fill_index;
  tag_t   fill_tag;

  // Address split above the byte offset
  assign lookup_index = lookup_addr_i[byte_offset_bits +: index_bits];
  assign lookup_tag   = lookup_addr_i[addr_width-1 -: tag_bits];
  assign fill_index   = fill_addr_i[byte_offset_bits +: index_bits];
  assign fill_tag     = fill_addr_i[addr_width-1 -: tag_bits];

  // Valid bits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (clear_i) begin
      valid_q[clear_index_i] <= 1'b0;
    end else if (fill_i) begin
      valid_q[fill_index] <= 1'b1;
    end
  end

  // Line contents and the refill error of each line
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      error_q[fill_index] <= fill_error_i;
      tag_q[fill_index]   <= fill_tag;
      data_q[fill_index]  <= fill_data_i;
    end
  end

  assign hit_o   = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
  assign data_o  = data_q[lookup_index];
  assign error_o = error_q[lookup_index];

endmodule : roc_line_store

`default_nettype wire

// ==== roc_flush_counter.sv ====
// --------------------------------------------------
// Flush counter
// Walks the line indices one per step during a flush
// and flags the final index
// --------------------------------------------------

`default_nettype none

module roc_flush_counter #(
  parameter int unsigned line_count = 16
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          start_i,
  input  logic                          step_i,
  output logic [$clog2(line_count)-1:0] index_o,
  output logic                          last_o
);

  localparam int unsigned index_bits = $clog2(line_count);

  logic [index_bits-1:0] index_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      index_q <= '0;
    end else if (start_i) begin
      index_q <= '0;
    end else if (step_i) begin
      index_q <= index_q + 1'b1;
    end
  end

  assign index_o = index_q;
  assign last_o  = (index_q == index_bits'(line_count - 1));

endmodule : roc_flush_counter

`default_nettype wire

// ==== roc_region_select.sv ====
// --------------------------------------------------
// Region select
// Marks a read as cacheable when the cache is on, the
// access is not locked and the address falls inside
// the half-open region [start, end)
// --------------------------------------------------

`default_nettype none

module roc_region_select (
  input  logic          enable_i,
  input  roc_pkg::addr_t req_addr_i,
  input  logic          req_lock_i,
  input  roc_pkg::addr_t start_addr_i,
  input  roc_pkg::addr_t end_addr_i,
  output logic          cacheable_o
);

  logic in_region;

  // End address is exclusive
  assign in_region = (req_addr_i >= start_addr_i) && (req_addr_i < end_addr_i);

  always_comb begin
    cacheable_o = in_region;
    // Atomic accesses always go to memory
    if (req_lock_i) begin
      cacheable_o = 1'b0;
    end
    // Cache disabled
    if (!enable_i) begin
      cacheable_o = 1'b0;
    end
  end

endmodule : roc_region_select

`default_nettype wire

// ==== roc_pkg.sv ====
// --------------------------------------------------
// Read-only cache shared definitions
// Address and word widths, vector types and the
// controller state encoding
// --------------------------------------------------

`default_nettype none

package roc_pkg;

  // Byte address and data word widths
  localparam int unsigned addr_width = 32;
  localparam int unsigned word_width = 32;

  // Address bits below word granularity, ignored for indexing
  localparam int unsigned byte_offset_bits = 2;

  // Byte address
  typedef logic [addr_width-1:0] addr_t;

  // One data word, which is also one cache line
  typedef logic [word_width-1:0] word_t;

  // Controller sequencing states
  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_refill,
    st_bypass,
    st_respond,
    st_flush
  } ctrl_state_e;

endpackage : roc_pkg

`default_nettype wire
